// File: Makefile
# Verilator build and run for the integer execute pipeline

VERILATOR ?= verilator
TOP       ?= int_exec_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

PASS_MSG  := \*\*\* TEST PASSED \*\*\*

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim.f
source/exec_pkg.sv
source/ex_stage_if.sv
source/reg_file.sv
source/instr_decode.sv
source/alu.sv
source/int_exec_top.sv
tb/int_exec_tb.sv

// File: source/alu.sv
/*
 * Execute stage of the integer execute pipeline.
 * One shared adder handles add, sub and slt, the remaining
 * operations run in parallel and a one-hot AND-OR merge picks
 * the result. The result feeds the decode bypass, the register
 * file write port and the registered writeback outputs.
 */
`timescale 1ns/1ps

module alu (
	input  logic               clk,
	input  logic               arst_n,
	ex_stage_if.ex             ex,
	output logic               wb_valid,
	output exec_pkg::reg_idx_t wb_rd,
	output exec_pkg::word_t    wb_data,
	output logic               wr_en,
	output exec_pkg::reg_idx_t wr_addr,
	output exec_pkg::word_t    wr_data
);

	localparam int MSB = exec_pkg::XLEN - 1;

	exec_pkg::word_t src1;
	exec_pkg::word_t src2;
	assign src1 = ex.src1;
	assign src2 = ex.src2;

	// ====================
	// Logic and shifts
	// ====================
	exec_pkg::word_t xor_res;
	exec_pkg::word_t or_res;
	exec_pkg::word_t and_res;
	exec_pkg::word_t srl_res;
	exec_pkg::word_t sra_res;
	exec_pkg::word_t sll_res;

	assign xor_res = src1 ^ src2;
	assign or_res  = src1 | src2;
	assign and_res = src1 & src2;
	// Shift amount from low 5 bits only
	assign srl_res = src1 >> src2[4:0];
	assign sra_res = $signed(src1) >>> src2[4:0];
	assign sll_res = src1 << src2[4:0];

	// ====================
	// Shared adder
	// ====================
	logic            adder_cin;
	exec_pkg::word_t adder_in2;
	exec_pkg::word_t adder_res;
	logic            overflow;
	logic            lt_res;
	logic            ltu_res;

	// Subtract by invert plus carry-in
	assign adder_cin = ex.op[exec_pkg::OP_SUB] | ex.op[exec_pkg::OP_SLT];
	assign adder_in2 = adder_cin ? ~src2 : src2;
	assign adder_res = src1 + adder_in2 + {{MSB{1'b0}}, adder_cin};

	// Operand signs differ and result sign differs from src1
	assign overflow = (src1[MSB] ^ src2[MSB]) & (src1[MSB] ^ adder_res[MSB]);
	assign lt_res   = adder_res[MSB] ^ overflow;
	assign ltu_res  = src1 < src2;

	// ====================
	// Result merge
	// ====================
	exec_pkg::word_t result;

	assign result = {exec_pkg::XLEN{ex.op[exec_pkg::OP_ADD] | ex.op[exec_pkg::OP_SUB]}} & adder_res
		| {exec_pkg::XLEN{ex.op[exec_pkg::OP_XOR]}}  & xor_res
		| {exec_pkg::XLEN{ex.op[exec_pkg::OP_OR]}}   & or_res
		| {exec_pkg::XLEN{ex.op[exec_pkg::OP_AND]}}  & and_res
		| {exec_pkg::XLEN{ex.op[exec_pkg::OP_SRL]}}  & srl_res
		| {exec_pkg::XLEN{ex.op[exec_pkg::OP_SRA]}}  & sra_res
		| {exec_pkg::XLEN{ex.op[exec_pkg::OP_SLL]}}  & sll_res
		| {exec_pkg::XLEN{ex.op[exec_pkg::OP_SLTU]}} & {{MSB{1'b0}}, ltu_res}
		| {exec_pkg::XLEN{ex.op[exec_pkg::OP_SLT]}}  & {{MSB{1'b0}}, lt_res};

	// Bypass back to decode, same cycle
	assign ex.byp_valid = ex.valid;
	assign ex.byp_rd    = ex.rd;
	assign ex.byp_data  = result;

	// Register file written at the end of this cycle
	assign wr_en   = ex.valid;
	assign wr_addr = ex.rd;
	assign wr_data = result;

	// ====================
	// Writeback register
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= ex.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (ex.valid) begin
			wb_rd   <= ex.rd;
			wb_data <= result;
		end
	end

	// Decode must hand over exactly one select
	a_op_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		ex.valid |-> $onehot(ex.op));

	// Operands from regfile or bypass are always known
	a_wb_known: assert property (@(posedge clk) disable iff (!arst_n)
		wb_valid |-> !$isunknown({wb_rd, wb_data}));

endmodule

// File: source/ex_stage_if.sv
/*
 * Decode to execute bundle.
 * Carries the registered ALU operation forward and the
 * combinational result of the instruction in execute back
 * to decode for operand bypass.
 */
`timescale 1ns/1ps

interface ex_stage_if;

	// Forward direction, one-cycle strobe
	logic                valid;
	exec_pkg::alu_op_t   op;
	exec_pkg::word_t     src1;
	exec_pkg::word_t     src2;
	exec_pkg::reg_idx_t  rd;

	// Bypass from execute
	logic                byp_valid;
	exec_pkg::reg_idx_t  byp_rd;
	exec_pkg::word_t     byp_data;

	modport dec (
		output valid, op, src1, src2, rd,
		input  byp_valid, byp_rd, byp_data
	);

	modport ex (
		input  valid, op, src1, src2, rd,
		output byp_valid, byp_rd, byp_data
	);

endinterface

// File: source/exec_pkg.sv
/*
 * Shared definitions for the RV32I integer execute pipeline.
 * Widths, typedefs, one-hot ALU select positions and the
 * opcode, funct3 and funct7 encodings of the OP and OP-IMM groups.
 */
package exec_pkg;

	// ====================
	// Widths and types
	// ====================
	localparam int XLEN      = 32;
	localparam int REG_IDX_W = 5;
	localparam int ALU_OP_W  = 10;

	typedef logic [XLEN-1:0]      word_t;
	typedef logic [XLEN-1:0]      instr_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [ALU_OP_W-1:0]  alu_op_t;

	// One-hot ALU select bit positions
	localparam int OP_ADD  = 0;
	localparam int OP_SUB  = 1;
	localparam int OP_XOR  = 2;
	localparam int OP_OR   = 3;
	localparam int OP_AND  = 4;
	localparam int OP_SRL  = 5;
	localparam int OP_SRA  = 6;
	localparam int OP_SLL  = 7;
	localparam int OP_SLTU = 8;
	localparam int OP_SLT  = 9;

	// ====================
	// Encodings
	// ====================
	localparam logic [6:0] OPCODE_OP     = 7'b0110011;
	localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// Alternate funct7 selects sub and sra
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

// File: source/instr_decode.sv
/*
 * Decode stage of the integer execute pipeline.
 * Splits OP and OP-IMM instructions into fields, builds the one-hot
 * ALU select, picks operands from the register file or the execute
 * bypass and registers the bundle for execute. Anything else is
 * reported as illegal one cycle after it is sampled.
 */
`timescale 1ns/1ps

module instr_decode (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               instr_valid,
	input  exec_pkg::instr_t   instr,
	output exec_pkg::reg_idx_t rs1_addr,
	output exec_pkg::reg_idx_t rs2_addr,
	input  exec_pkg::word_t    rs1_data,
	input  exec_pkg::word_t    rs2_data,
	output logic               illegal,
	ex_stage_if.dec            ex
);

	// ====================
	// Instruction fields
	// ====================
	logic [6:0]         opcode;
	logic [2:0]         funct3;
	logic [6:0]         funct7;
	exec_pkg::reg_idx_t rd;

	assign opcode   = instr[6:0];
	assign rd       = instr[11:7];
	assign funct3   = instr[14:12];
	assign rs1_addr = instr[19:15];
	assign rs2_addr = instr[24:20];
	assign funct7   = instr[31:25];

	logic is_op;
	logic is_imm;
	logic is_shift;
	logic f7_base;
	logic f7_alt;
	logic f7_ok;
	logic use_alt;
	logic legal;

	assign is_op    = (opcode == exec_pkg::OPCODE_OP);
	assign is_imm   = (opcode == exec_pkg::OPCODE_OP_IMM);
	assign is_shift = (funct3 == exec_pkg::F3_SLL) || (funct3 == exec_pkg::F3_SR);
	assign f7_base  = (funct7 == exec_pkg::F7_BASE);
	assign f7_alt   = (funct7 == exec_pkg::F7_ALT);

	// funct7 rules differ per group
	// OP checks it everywhere, OP-IMM only for the shifts
	always_comb begin
		if (is_op) begin
			f7_ok = f7_base
				|| (f7_alt && ((funct3 == exec_pkg::F3_ADD_SUB) || (funct3 == exec_pkg::F3_SR)));
		end else if (funct3 == exec_pkg::F3_SLL) begin
			f7_ok = f7_base;
		end else if (funct3 == exec_pkg::F3_SR) begin
			f7_ok = f7_base || f7_alt;
		end else begin
			// Upper immediate bits, any value
			f7_ok = 1'b1;
		end
	end

	assign legal = (is_op || is_imm) && f7_ok;

	// Alternate encoding, never for addi
	assign use_alt = f7_alt && (is_op || (funct3 == exec_pkg::F3_SR));

	// ====================
	// One-hot ALU select
	// ====================
	exec_pkg::alu_op_t op;

	always_comb begin
		op = '0;
		case (funct3)
			exec_pkg::F3_ADD_SUB: op[use_alt ? exec_pkg::OP_SUB : exec_pkg::OP_ADD] = 1'b1;
			exec_pkg::F3_SLL:     op[exec_pkg::OP_SLL]  = 1'b1;
			exec_pkg::F3_SLT:     op[exec_pkg::OP_SLT]  = 1'b1;
			exec_pkg::F3_SLTU:    op[exec_pkg::OP_SLTU] = 1'b1;
			exec_pkg::F3_XOR:     op[exec_pkg::OP_XOR]  = 1'b1;
			exec_pkg::F3_SR:      op[use_alt ? exec_pkg::OP_SRA : exec_pkg::OP_SRL] = 1'b1;
			exec_pkg::F3_OR:      op[exec_pkg::OP_OR]   = 1'b1;
			exec_pkg::F3_AND:     op[exec_pkg::OP_AND]  = 1'b1;
		endcase
	end

	// ====================
	// Operand select
	// ====================
	exec_pkg::word_t rs1_fwd;
	exec_pkg::word_t rs2_fwd;
	exec_pkg::word_t imm_i;
	exec_pkg::word_t shamt;
	exec_pkg::word_t src2;

	// Bypass the instruction now in execute, never for x0
	assign rs1_fwd = (ex.byp_valid && (ex.byp_rd == rs1_addr) && (ex.byp_rd != '0))
		? ex.byp_data : rs1_data;
	assign rs2_fwd = (ex.byp_valid && (ex.byp_rd == rs2_addr) && (ex.byp_rd != '0))
		? ex.byp_data : rs2_data;

	assign imm_i = {{(exec_pkg::XLEN - 12){instr[31]}}, instr[31:20]};
	assign shamt = {{(exec_pkg::XLEN - 5){1'b0}}, instr[24:20]};
	assign src2  = is_op ? rs2_fwd : (is_shift ? shamt : imm_i);

	// ====================
	// Stage register
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex.valid <= 1'b0;
			illegal  <= 1'b0;
		end else begin
			ex.valid <= instr_valid && legal;
			illegal  <= instr_valid && !legal;
		end
	end

	// Payload only moves with a sampled instruction
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			ex.op   <= op;
			ex.src1 <= rs1_fwd;
			ex.src2 <= src2;
			ex.rd   <= rd;
		end
	end

	// Every sampled instruction is either issued or flagged, never both
	a_issue_or_flag: assert property (@(posedge clk) disable iff (!arst_n)
		instr_valid |=> $onehot({ex.valid, illegal}));

endmodule

// File: source/int_exec_top.sv
/*
 * Top level of the RV32I integer execute pipeline.
 * Connects decode, register file and execute, two stages
 * deep with a fixed writeback latency.
 */
`timescale 1ns/1ps

module int_exec_top (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               instr_valid,
	input  exec_pkg::instr_t   instr,
	output logic               wb_valid,
	output exec_pkg::reg_idx_t wb_rd,
	output exec_pkg::word_t    wb_data,
	output logic               illegal
);

	// Read port wires
	exec_pkg::reg_idx_t rs1_addr;
	exec_pkg::reg_idx_t rs2_addr;
	exec_pkg::word_t    rs1_data;
	exec_pkg::word_t    rs2_data;

	// Write port wires
	logic               wr_en;
	exec_pkg::reg_idx_t wr_addr;
	exec_pkg::word_t    wr_data;

	ex_stage_if ex_bus ();

	// ====================
	// Stages
	// ====================
	instr_decode u_decode (
		.clk, .arst_n, .instr_valid, .instr,
		.rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
		.illegal, .ex(ex_bus.dec)
	);

	reg_file u_regs (
		.clk, .arst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
		.wr_en, .wr_addr, .wr_data
	);

	alu u_alu (
		.clk, .arst_n, .ex(ex_bus.ex),
		.wb_valid, .wb_rd, .wb_data,
		.wr_en, .wr_addr, .wr_data
	);

endmodule

// File: source/reg_file.sv
/*
 * Integer register file, 32 entries of 32 bits.
 * Two asynchronous read ports and one synchronous write port.
 * Writes to x0 are dropped so x0 always reads zero.
 */
`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  logic               arst_n,
	input  exec_pkg::reg_idx_t rs1_addr,
	input  exec_pkg::reg_idx_t rs2_addr,
	output exec_pkg::word_t    rs1_data,
	output exec_pkg::word_t    rs2_data,
	input  logic               wr_en,
	input  exec_pkg::reg_idx_t wr_addr,
	input  exec_pkg::word_t    wr_data
);

	exec_pkg::word_t regs [2**exec_pkg::REG_IDX_W];

	// x0 is never a write target
	logic wr_ok;
	assign wr_ok = wr_en && (wr_addr != '0);

	// ====================
	// Write port
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// Architectural state starts at zero
			regs <= '{default: '0};
		end else if (wr_ok) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// ====================
	// Read ports
	// ====================
	// Combinational, bypass of same-cycle writes is done in decode
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

endmodule

// File: tb/int_exec_tb.sv
/*
 * Testbench for the RV32I integer execute pipeline.
 * Drives directed and random OP / OP-IMM traffic, keeps a
 * reference register array updated at issue time and checks
 * writeback and illegal strobes with concurrent assertions.
 */
`timescale 1ns/1ps

module int_exec_tb;

	localparam int TIMEOUT = 2000;
	localparam int N_RAND  = 600;

	logic                clk;
	logic                arst_n;
	logic                instr_valid;
	exec_pkg::instr_t    instr;
	logic                wb_valid;
	exec_pkg::reg_idx_t  wb_rd;
	exec_pkg::word_t     wb_data;
	logic                illegal;

	int errors;
	int cycles;

	// Reference architectural state
	exec_pkg::word_t ref_regs [32];

	// Expectation of the instruction being driven now
	logic               cur_valid;
	logic               cur_ill;
	exec_pkg::reg_idx_t cur_rd;
	exec_pkg::word_t    cur_data;

	// Expectations one and two edges after issue
	logic               exp1_valid;
	logic               exp1_ill;
	exec_pkg::reg_idx_t exp1_rd;
	exec_pkg::word_t    exp1_data;
	logic               exp2_valid;
	exec_pkg::reg_idx_t exp2_rd;
	exec_pkg::word_t    exp2_data;

	int_exec_top dut_i (
		.clk, .arst_n, .instr_valid, .instr,
		.wb_valid, .wb_rd, .wb_data, .illegal
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ====================
	// Expected pipeline
	// ====================
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exp1_valid <= 1'b0;
			exp1_ill   <= 1'b0;
			exp1_rd    <= '0;
			exp1_data  <= '0;
			exp2_valid <= 1'b0;
			exp2_rd    <= '0;
			exp2_data  <= '0;
		end else begin
			exp1_valid <= cur_valid;
			exp1_ill   <= cur_ill;
			exp1_rd    <= cur_rd;
			exp1_data  <= cur_data;
			exp2_valid <= exp1_valid;
			exp2_rd    <= exp1_rd;
			exp2_data  <= exp1_data;
		end
	end

	// ====================
	// Checks
	// ====================
	a_illegal: assert property (@(posedge clk) disable iff (!arst_n) illegal == exp1_ill)
		else begin
			errors++;
			$display("Error at %0t: illegal expected %b got %b", $time,
				$sampled(exp1_ill), $sampled(illegal));
		end

	a_wb_valid: assert property (@(posedge clk) disable iff (!arst_n) wb_valid == exp2_valid)
		else begin
			errors++;
			$display("Error at %0t: wb_valid expected %b got %b", $time,
				$sampled(exp2_valid), $sampled(wb_valid));
		end

	a_wb_rd: assert property (@(posedge clk) disable iff (!arst_n)
		exp2_valid |-> wb_rd == exp2_rd)
		else begin
			errors++;
			$display("Error at %0t: wb_rd expected %0d got %0d", $time,
				$sampled(exp2_rd), $sampled(wb_rd));
		end

	a_wb_data: assert property (@(posedge clk) disable iff (!arst_n)
		exp2_valid |-> wb_data == exp2_data)
		else begin
			errors++;
			$display("Error at %0t: wb_data expected %h got %h", $time,
				$sampled(exp2_data), $sampled(wb_data));
		end

	// Hard stop on a stuck run
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: run did not finish within %0d cycles, errors: %0d",
				TIMEOUT, errors);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ====================
	// Encoders
	// ====================
	function automatic exec_pkg::instr_t encode_r(input logic [6:0] f7, input logic [2:0] f3,
		input exec_pkg::reg_idx_t rd, input exec_pkg::reg_idx_t rs1,
		input exec_pkg::reg_idx_t rs2);
		return {f7, rs2, rs1, f3, rd, exec_pkg::OPCODE_OP};
	endfunction

	function automatic exec_pkg::instr_t encode_i(input logic [11:0] imm, input logic [2:0] f3,
		input exec_pkg::reg_idx_t rd, input exec_pkg::reg_idx_t rs1);
		return {imm, rs1, f3, rd, exec_pkg::OPCODE_OP_IMM};
	endfunction

	// Drive one instruction and work out its expected outcome from the ISA rules
	task automatic issue(input exec_pkg::instr_t w);
		logic [6:0]      opc;
		logic [2:0]      f3;
		logic [6:0]      f7;
		logic            ok;
		logic            alt;
		exec_pkg::word_t a;
		exec_pkg::word_t b;
		exec_pkg::word_t res;
		opc = w[6:0];
		f3  = w[14:12];
		f7  = w[31:25];
		a   = ref_regs[w[19:15]];
		res = '0;
		if (opc == exec_pkg::OPCODE_OP) begin
			b   = ref_regs[w[24:20]];
			alt = (f7 == exec_pkg::F7_ALT);
			ok  = (f7 == exec_pkg::F7_BASE)
				|| (alt && (f3 == exec_pkg::F3_ADD_SUB || f3 == exec_pkg::F3_SR));
		end else begin
			b   = {{20{w[31]}}, w[31:20]};
			alt = (f3 == exec_pkg::F3_SR) && (f7 == exec_pkg::F7_ALT);
			if (f3 == exec_pkg::F3_SLL)
				ok = (f7 == exec_pkg::F7_BASE);
			else if (f3 == exec_pkg::F3_SR)
				ok = (f7 == exec_pkg::F7_BASE) || alt;
			else
				ok = 1'b1;
			ok = ok && (opc == exec_pkg::OPCODE_OP_IMM);
		end
		case (f3)
			exec_pkg::F3_ADD_SUB: res = alt ? a - b : a + b;
			exec_pkg::F3_SLL:     res = a << b[4:0];
			exec_pkg::F3_SLT:     res = {31'b0, $signed(a) < $signed(b)};
			exec_pkg::F3_SLTU:    res = {31'b0, a < b};
			exec_pkg::F3_XOR:     res = a ^ b;
			exec_pkg::F3_SR: begin
				if (alt)
					res = $signed(a) >>> b[4:0];
				else
					res = a >> b[4:0];
			end
			exec_pkg::F3_OR:      res = a | b;
			default:              res = a & b;
		endcase
		// x0 stays zero in the model
		if (ok && w[11:7] != 5'd0)
			ref_regs[w[11:7]] = res;
		instr_valid = 1'b1;
		instr       = w;
		cur_valid   = ok;
		cur_ill     = !ok;
		cur_rd      = w[11:7];
		cur_data    = res;
		@(posedge clk);
		#1;
	endtask

	task automatic idle(input int n);
		instr_valid = 1'b0;
		instr       = '0;
		cur_valid   = 1'b0;
		cur_ill     = 1'b0;
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Mostly legal traffic with some bad funct7 and foreign opcodes
	function automatic exec_pkg::instr_t random_instr();
		exec_pkg::word_t r;
		exec_pkg::word_t s;
		logic [6:0]      f7;
		r  = $urandom;
		s  = $urandom;
		f7 = s[12] ? exec_pkg::F7_ALT : exec_pkg::F7_BASE;
		if (r[3:0] == 4'd6)
			f7 = s[19:13];
		if (r[3:0] < 4'd7)
			return encode_r(f7, r[21:19], r[8:4], r[13:9], r[18:14]);
		else if (r[3:0] < 4'd14)
			return encode_i({f7, s[4:0]}, r[21:19], r[8:4], r[13:9]);
		else
			return {r[31:7], s[26:20]};
	endfunction

	// ====================
	// Stimulus
	// ====================
	initial begin
		exec_pkg::word_t r;
		errors      = 0;
		cycles      = 0;
		arst_n      = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		cur_valid   = 1'b0;
		cur_ill     = 1'b0;
		cur_rd      = '0;
		cur_data    = '0;
		for (int i = 0; i < 32; i++)
			ref_regs[i] = '0;
		void'($urandom(32'h1632));
		#1 arst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1 arst_n = 1'b1;

		// Every register reads zero after reset
		for (int i = 1; i < 32; i++)
			issue(encode_r(exec_pkg::F7_BASE, exec_pkg::F3_ADD_SUB, 5'(i), 5'(i), 5'd0));
		idle(2);

		// Boundary operands x1..x4
		issue(encode_i(12'd1, exec_pkg::F3_ADD_SUB, 5'd1, 5'd0));
		issue(encode_i({exec_pkg::F7_BASE, 5'd31}, exec_pkg::F3_SLL, 5'd1, 5'd1));
		issue(encode_i(12'hfff, exec_pkg::F3_ADD_SUB, 5'd2, 5'd0));
		issue(encode_i({exec_pkg::F7_BASE, 5'd1}, exec_pkg::F3_SR, 5'd2, 5'd2));
		issue(encode_i(12'hfff, exec_pkg::F3_ADD_SUB, 5'd3, 5'd0));
		issue(encode_i(12'd1, exec_pkg::F3_ADD_SUB, 5'd4, 5'd0));

		// All R-type ops over all operand pairs including sub overflow
		for (int f = 0; f < 8; f++)
			for (int alt = 0; alt < 2; alt++)
				if (alt == 0 || f == 0 || f == 5)
					for (int a = 1; a < 5; a++)
						for (int b = 1; b < 5; b++)
							issue(encode_r(alt ? exec_pkg::F7_ALT : exec_pkg::F7_BASE,
								3'(f), 5'd10, 5'(a), 5'(b)));

		// I-type with sign-extended immediates
		issue(encode_i(12'h800, exec_pkg::F3_ADD_SUB, 5'd11, 5'd2));
		issue(encode_i(12'h7ff, exec_pkg::F3_ADD_SUB, 5'd11, 5'd3));
		issue(encode_i(12'hfff, exec_pkg::F3_SLT, 5'd11, 5'd1));
		issue(encode_i(12'hfff, exec_pkg::F3_SLTU, 5'd11, 5'd4));
		issue(encode_i(12'hfff, exec_pkg::F3_XOR, 5'd11, 5'd3));
		issue(encode_i(12'h8f0, exec_pkg::F3_AND, 5'd11, 5'd3));
		issue(encode_i(12'h80f, exec_pkg::F3_OR, 5'd11, 5'd4));
		issue(encode_i({exec_pkg::F7_ALT, 5'd4}, exec_pkg::F3_SR, 5'd11, 5'd1));
		issue(encode_i({exec_pkg::F7_BASE, 5'd4}, exec_pkg::F3_SR, 5'd11, 5'd1));

		// Bypass then register file read
		issue(encode_r(exec_pkg::F7_BASE, exec_pkg::F3_ADD_SUB, 5'd12, 5'd1, 5'd4));
		issue(encode_r(exec_pkg::F7_BASE, exec_pkg::F3_ADD_SUB, 5'd13, 5'd12, 5'd12));
		issue(encode_r(exec_pkg::F7_ALT, exec_pkg::F3_ADD_SUB, 5'd14, 5'd12, 5'd13));
		idle(1);
		issue(encode_r(exec_pkg::F7_BASE, exec_pkg::F3_XOR, 5'd15, 5'd13, 5'd14));

		// Write to x0 then read it back
		issue(encode_i(12'd5, exec_pkg::F3_ADD_SUB, 5'd0, 5'd0));
		issue(encode_r(exec_pkg::F7_BASE, exec_pkg::F3_OR, 5'd16, 5'd0, 5'd0));
		idle(1);
		issue(encode_r(exec_pkg::F7_BASE, exec_pkg::F3_OR, 5'd16, 5'd0, 5'd4));

		// Illegal encodings
		issue({25'h0a5a5a5, 7'b0000011});
		issue({25'h1234567, 7'b0100011});
		issue({25'h0fedcba, 7'b1100011});
		issue({25'h1111111, 7'b1101111});
		issue({25'h0000aaa, 7'b0110111});
		issue({25'h0000bbb, 7'b0010111});
		issue(encode_r(7'b0000001, exec_pkg::F3_ADD_SUB, 5'd17, 5'd1, 5'd2));
		issue(encode_r(exec_pkg::F7_ALT, exec_pkg::F3_XOR, 5'd17, 5'd1, 5'd2));
		issue(encode_i({exec_pkg::F7_ALT, 5'd3}, exec_pkg::F3_SLL, 5'd17, 5'd1));
		issue(encode_i({7'b0010000, 5'd3}, exec_pkg::F3_SR, 5'd17, 5'd1));

		// Random traffic with idle gaps
		for (int n = 0; n < N_RAND; n++) begin
			r = $urandom;
			if (r[2:0] == 3'd0)
				idle(1);
			else
				issue(random_instr());
		end
		idle(4);

		$display("Run complete, errors: %0d", errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
